// File: cpu.f
verilog/cpu_pkg.sv
verilog/alu.sv
verilog/decoder.sv
verilog/reg_file.sv
verilog/mem_unit.sv
verilog/cpu_ctrl.sv
verilog/cpu.sv
verification/cpu_assertions.sv
verification/cpu_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module cpu_tb -Mdir obj_dir -f cpu.f
	./obj_dir/Vcpu_tb +verilator+error+limit+1000 | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log

// File: verification/cpu_tb.sv
// rv32i core testbench
`default_nettype none
`timescale 1ns/1ns

module cpu_tb import cpu_pkg::*; ();

  localparam int    LOOP_N         = 5;             // countdown iterations
  localparam int    STEP           = 3;             // added to x10 per call
  localparam word_t STORE_WORD     = 32'h1234_8a83; // negative low byte and low half
  localparam int    NUM_INSTR      = 25 + 5 * LOOP_N;
  localparam int    TIMEOUT_CYCLES = NUM_INSTR * 40 * 4;

  logic  clk_in, rst_n, rdy_in, io_buffer_full, mem_wr;
  byte_t mem_din, mem_dout;
  word_t mem_a, dbgreg_dout;

  byte_t       mem [0:131071]; // 128 KB ram
  byte_t       uart_q [$];     // bytes sent to 0x30000
  word_t       a0_at_uart;     // x10 when the first uart byte goes out
  word_t       bus_a;
  word_t       park_a;
  logic [31:0] seed = 32'he881;
  int          halt_cnt = 0;
  int          late_writes = 0; // bus writes after the halt store
  int          errs = 0;
  int          n_tests = 0;
  int          n_failed = 0;
  int          load_pc;

  cpu u_dut (
    .clk_in(clk_in), .rst_n(rst_n), .rdy_in(rdy_in),
    .mem_din(mem_din), .mem_dout(mem_dout), .mem_a(mem_a), .mem_wr(mem_wr),
    .io_buffer_full(io_buffer_full), .dbgreg_dout(dbgreg_dout)
  );

  bind cpu cpu_assertions u_chk (
    .clk_in(clk_in), .rst_n(rst_n), .rdy_in(rdy_in), .io_buffer_full(io_buffer_full),
    .mem_wr(mem_wr), .mem_a(mem_a), .req(req), .ack(ack), .state(u_ctrl.state)
  );

  initial clk_in = 1'b0;
  always #4 clk_in = ~clk_in; // 8 ns period

  // rv32i instruction formats
  function automatic word_t itype(int imm, int rs1, int f3, int rd, int opc);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
  endfunction

  function automatic word_t rtype(int f7, int rs2, int rs1, int f3, int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
  endfunction

  function automatic word_t stype(int imm, int rs2, int rs1, int f3);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'h23};
  endfunction

  function automatic word_t btype(int imm, int rs2, int rs1, int f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic word_t utype(int imm, int rd, int opc);
    return {imm[19:0], rd[4:0], opc[6:0]};
  endfunction

  function automatic word_t jtype(int imm, int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
  endfunction

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // lb + lbu + lh + lhu + lw of one stored word
  function automatic word_t load_sum(input word_t w);
    return {{24{w[7]}}, w[7:0]} + {24'd0, w[7:0]} + {{16{w[15]}}, w[15:0]}
         + {16'd0, w[15:0]} + w;
  endfunction

  task automatic emit(input word_t w);
    for (int i = 0; i < 4; i++)
      mem[17'(load_pc + i)] = w[8*i +: 8]; // little endian
    load_pc += 4;
  endtask

  task automatic load_program();
    for (int i = 0; i < 131072; i++)
      mem[17'(i)] = 8'(i ^ (i >> 8) ^ (i >> 16));
    load_pc = 0;
    emit(utype('h30, 5, 'h37));                      // 00 lui x5, io base
    emit(itype(0, 0, 0, 10, 'h13));                  // 04 x10 = 0
    emit(itype(LOOP_N, 0, 0, 20, 'h13));             // 08 x20 = count
    emit(jtype('h70 - 'h0c, 1));                     // 0c loop: call add_step
    emit(itype(-1, 20, 0, 20, 'h13));                // 10 x20--
    emit(btype(-8, 0, 20, 1));                       // 14 bne back to loop
    emit(itype(9, 0, 0, 6, 'h13));                   // 18 x6 = 9
    emit(itype(3, 6, 1, 6, 'h13));                   // 1c slli x6, 3
    emit(itype(7, 0, 0, 7, 'h13));                   // 20 x7 = 7
    emit(rtype(0, 7, 6, 0, 8));                      // 24 add x8 = x6 + x7
    emit(stype(0, 8, 5, 0));                         // 28 sb first char
    emit(rtype(0, 6, 0, 2, 9));                      // 2c slt x9 = 0 < x6
    emit(itype(2, 9, 1, 9, 'h13));                   // 30 slli x9, 2
    emit(rtype(0, 9, 8, 4, 8));                      // 34 xor x8 ^= x9
    emit(stype(0, 8, 5, 0));                         // 38 sb second char
    emit(utype(int'((STORE_WORD + 32'h800) >> 12), 11, 'h37)); // 3c
    emit(itype(int'(STORE_WORD[11:0]), 11, 0, 11, 'h13));      // 40 addi low part
    emit(stype('h100, 11, 0, 2));                    // 44 sw
    emit(itype('h100, 0, 0, 12, 'h03));              // 48 lb
    emit(itype('h100, 0, 4, 13, 'h03));              // 4c lbu
    emit(itype('h100, 0, 1, 14, 'h03));              // 50 lh
    emit(itype('h100, 0, 5, 15, 'h03));              // 54 lhu
    emit(itype('h100, 0, 2, 16, 'h03));              // 58 lw
    emit(rtype(0, 13, 12, 0, 10));                   // 5c sum into x10
    emit(rtype(0, 14, 10, 0, 10));
    emit(rtype(0, 15, 10, 0, 10));
    emit(rtype(0, 16, 10, 0, 10));                   // 68
    emit(stype(4, 0, 5, 0));                         // 6c sb to halt port
    emit(itype(STEP, 10, 0, 10, 'h13));              // 70 add_step: x10 += step
    emit(itype(0, 1, 0, 0, 'h67));                   // 74 jalr x0, 0(x1)
  endtask

  task automatic check_value(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
      errs++;
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    n_tests++;
    if (errs == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      n_failed++;
      $display("test %s: failed", name);
    end
  endtask

  task automatic record_write(input word_t a, input byte_t d);
    if (halt_cnt != 0)
      late_writes++;
    if (a[17:16] != 2'b11) begin
      mem[a[16:0]] = d;
    end else if (a[17:0] == IO_BASE[17:0]) begin
      if (uart_q.size() == 0)
        a0_at_uart = dbgreg_dout; // loop result still in x10 here
      if (d != 8'd0)
        uart_q.push_back(d);      // uart drops zero bytes
    end else if (a[17:0] == IO_HALT[17:0]) begin
      halt_cnt++;
    end
  endtask

  // memory model and random pause stimulus
  always begin
    @(posedge clk_in);
    bus_a = mem_a; // value from before the edge
    if (mem_wr)
      record_write(bus_a, mem_dout);
    #1;
    mem_din = mem[bus_a[16:0]];      // read answered one cycle later
    seed = lcg_next(seed);
    rdy_in = (seed[31:30] != 2'b00); // paused about a quarter of cycles
    io_buffer_full = seed[29];
  end

  initial begin
    word_t x6_exp, o_exp, k_exp;
    int mark;
    rst_n = 1'b0;
    rdy_in = 1'b1;
    io_buffer_full = 1'b0;
    mem_din = 8'd0;
    load_program();
    repeat (4) @(posedge clk_in);
    #1 rst_n = 1'b1;
    wait (halt_cnt != 0);
    repeat (24) @(posedge clk_in); // halt store retires, pc parks
    park_a = mem_a;
    mark = errs;
    repeat (16) begin
      @(posedge clk_in);
      check_value("mem_a", mem_a, park_a);
    end
    check_value("halt writes", halt_cnt, 1);
    check_value("writes after halt", late_writes, 0);
    check_value("bus assertion failures", u_dut.u_chk.bus_fails, 0);
    finish_test("halt", mark);

    x6_exp = 32'd9 << 3;
    o_exp  = x6_exp + 32'd7;
    k_exp  = o_exp ^ ((($signed(x6_exp) > 0) ? 32'd1 : 32'd0) << 2);
    mark = errs;
    check_value("uart byte count", uart_q.size(), 2);
    if (uart_q.size() == 2) begin
      check_value("uart[0]", {24'd0, uart_q[0]}, o_exp);
      check_value("uart[1]", {24'd0, uart_q[1]}, k_exp);
    end
    finish_test("arithmetic", mark);

    mark = errs;
    check_value("dbgreg_dout", dbgreg_dout, load_sum(STORE_WORD));
    finish_test("load widths", mark);

    mark = errs;
    check_value("x10 after loop", a0_at_uart, LOOP_N * STEP);
    finish_test("branches and jumps", mark);

    mark = errs;
    check_value("pause assertion failures", u_dut.u_chk.pause_fails, 0);
    finish_test("pause", mark);

    mark = errs;
    check_value("reset assertion failures", u_dut.u_chk.reset_fails, 0);
    finish_test("reset", mark);

    $display("%0d tests, %0d passed, %0d failed, %0d check errors",
             n_tests, n_tests - n_failed, n_failed, errs);
    if (n_failed == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

  // watchdog
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk_in);
    $display("timeout: no halt store within %0d cycles", TIMEOUT_CYCLES);
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/cpu_assertions.sv
// core bus and pause assertions
`default_nettype none
`timescale 1ns/1ns

module cpu_assertions import cpu_pkg::*; (
  input wire              clk_in,
  input wire              rst_n,
  input wire              rdy_in,
  input wire              io_buffer_full,
  input wire              mem_wr,
  input wire word_t       mem_a,
  input wire              req,   // controller to memory unit
  input wire              ack,
  input wire ctrl_state_e state
);

  int   pause_fails = 0; // tallies per check group
  int   reset_fails = 0;
  int   bus_fails   = 0;
  logic halt_seen;       // halt store reached the bus

  always_ff @(posedge clk_in or negedge rst_n) begin
    if (!rst_n)
      halt_seen <= 1'b0;
    else if (mem_wr && mem_a[17:0] == IO_HALT[17:0])
      halt_seen <= 1'b1;
  end

  pause_no_write: assert property (@(posedge clk_in) disable iff (!rst_n)
    !rdy_in |-> !mem_wr)
  else begin
    $error("mem_wr high while rdy_in low");
    pause_fails++;
  end

  // frozen state keeps the address
  pause_addr_hold: assert property (@(posedge clk_in) disable iff (!rst_n)
    !rdy_in |=> $stable(mem_a))
  else begin
    $error("mem_a moved across a paused cycle");
    pause_fails++;
  end

  io_full_no_write: assert property (@(posedge clk_in) disable iff (!rst_n)
    io_buffer_full && mem_a[17:16] == 2'b11 |-> !mem_wr)
  else begin
    $error("i/o write while io_buffer_full high");
    pause_fails++;
  end

  reset_no_write: assert property (@(posedge clk_in) !rst_n |-> !mem_wr)
  else begin
    $error("mem_wr high during reset");
    reset_fails++;
  end

  reset_first_fetch: assert property (@(posedge clk_in) $rose(rst_n) |-> mem_a == RESET_PC)
  else begin
    $error("first bus address after reset is not the reset pc");
    reset_fails++;
  end

  // four-phase: req holds until ack
  req_held: assert property (@(posedge clk_in) disable iff (!rst_n)
    req && !ack |=> req)
  else begin
    $error("req dropped before ack");
    bus_fails++;
  end

  req_state: assert property (@(posedge clk_in) disable iff (!rst_n)
    req |-> (state == FETCH || state == MEM))
  else begin
    $error("req high outside fetch and memory states");
    bus_fails++;
  end

  halt_quiet: assert property (@(posedge clk_in) disable iff (!rst_n)
    halt_seen |-> !mem_wr)
  else begin
    $error("bus write after the halt store");
    bus_fails++;
  end

endmodule

`default_nettype wire

// File: verilog/cpu.sv
// rv32i core top
`default_nettype none
`timescale 1ns/1ns

module cpu import cpu_pkg::*; (
  input  wire        clk_in,         // system clock
  input  wire        rst_n,
  input  wire        rdy_in,         // pause core when low
  input  wire byte_t mem_din,        // read data, one cycle after mem_a
  output byte_t      mem_dout,
  output word_t      mem_a,          // only 17:0 decoded outside
  output logic       mem_wr,         // 1 for write
  input  wire        io_buffer_full, // uart buffer full
  output word_t      dbgreg_dout     // x10
);

  // controller <-> memory unit handshake
  logic req, ack, we, mem_sign;
  word_t addr, wdata, rdata;
  mem_size_e mem_size;

  // decoded fields
  word_t instr, imm;
  opcode_e opcode;
  alu_op_e alu_op;
  reg_idx_t rs1, rs2, rd, rd_idx;
  mem_size_e size;
  logic sign_ext;

  // datapath
  word_t alu_a, alu_b, alu_res;
  word_t rs1_val, rs2_val, rd_val;
  logic cmp_true, rd_we;

  cpu_ctrl u_ctrl (
    .clk_in(clk_in), .rst_n(rst_n), .rdy_in(rdy_in),
    .ack(ack), .rdata(rdata),
    .opcode(opcode), .alu_op(alu_op), .imm(imm),
    .rs1(rs1), .rs2(rs2), .rd(rd), .size(size), .sign_ext(sign_ext),
    .rs1_val(rs1_val), .rs2_val(rs2_val), .alu_res(alu_res), .alu_zero_cmp(cmp_true),
    .req(req), .addr(addr), .wdata(wdata), .we(we),
    .mem_size(mem_size), .mem_sign(mem_sign), .instr(instr),
    .alu_a(alu_a), .alu_b(alu_b),
    .rd_we(rd_we), .rd_idx(rd_idx), .rd_val(rd_val)
  );

  mem_unit u_mem (
    .clk_in(clk_in), .rst_n(rst_n), .rdy_in(rdy_in), .io_buffer_full(io_buffer_full),
    .req(req), .addr(addr), .wdata(wdata), .we(we),
    .size(mem_size), .sign_ext(mem_sign), .mem_din(mem_din),
    .ack(ack), .rdata(rdata),
    .mem_dout(mem_dout), .mem_a(mem_a), .mem_wr(mem_wr)
  );

  decoder u_dec (
    .instr(instr), .opcode(opcode), .alu_op(alu_op), .imm(imm),
    .rs1(rs1), .rs2(rs2), .rd(rd), .size(size), .sign_ext(sign_ext)
  );

  alu u_alu (.a(alu_a), .b(alu_b), .op(alu_op), .res(alu_res), .cmp_true(cmp_true));

  reg_file u_rf (
    .clk_in(clk_in), .rst_n(rst_n), .rdy_in(rdy_in),
    .rs1(rs1), .rs2(rs2), .we(rd_we), .rd(rd_idx), .wdata(rd_val),
    .rs1_val(rs1_val), .rs2_val(rs2_val), .dbg_a0(dbgreg_dout)
  );

endmodule

`default_nettype wire

// File: verilog/cpu_ctrl.sv
// multi-cycle controller
`default_nettype none
`timescale 1ns/1ns

module cpu_ctrl import cpu_pkg::*; (
  input  wire            clk_in,
  input  wire            rst_n,
  input  wire            rdy_in,
  input  wire            ack,          // from memory unit
  input  wire word_t     rdata,
  input  wire opcode_e   opcode,
  input  wire alu_op_e   alu_op,
  input  wire word_t     imm,
  input  wire reg_idx_t  rs1,
  input  wire reg_idx_t  rs2,
  input  wire reg_idx_t  rd,
  input  wire mem_size_e size,
  input  wire            sign_ext,
  input  wire word_t     rs1_val,
  input  wire word_t     rs2_val,
  input  wire word_t     alu_res,
  input  wire            alu_zero_cmp, // branch compare result
  output logic           req,
  output word_t          addr,
  output word_t          wdata,
  output logic           we,
  output mem_size_e      mem_size,
  output logic           mem_sign,
  output word_t          instr,
  output word_t          alu_a,
  output word_t          alu_b,
  output logic           rd_we,
  output reg_idx_t       rd_idx,
  output word_t          rd_val
);

  ctrl_state_e state;
  word_t pc, npc;            // npc committed in WB
  word_t ir, a_q, b_q, res_q;
  logic halted;              // set by a store to IO_HALT
  logic is_link, use_pc, use_rs2, is_load, is_store, writes_rd, is_cmp, taken, done;
  word_t pc_plus4, br_target;

  assign instr     = ir;
  assign pc_plus4  = pc + 32'd4;
  assign br_target = pc + imm;

  assign is_link   = (opcode == OPC_JAL) || (opcode == OPC_JALR);
  assign use_pc    = (opcode == OPC_AUIPC) || (opcode == OPC_JAL);
  assign use_rs2   = (opcode == OPC_OP) || (opcode == OPC_BRANCH);
  assign is_load   = opcode == OPC_LOAD;
  assign is_store  = opcode == OPC_STORE;
  assign writes_rd = opcode inside {OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR,
                                    OPC_LOAD, OPC_IMM, OPC_OP};
  assign is_cmp    = alu_op inside {ALU_EQ, ALU_SLT, ALU_SLTU}; // bad funct3 is never taken
  assign taken     = is_cmp && (alu_zero_cmp ^ ir[12]);         // funct3[0] inverts

  assign alu_a = use_pc ? pc : a_q;
  assign alu_b = use_rs2 ? b_q : imm;

  // bus request side, fetch is always a word at pc
  assign addr     = (state == MEM) ? alu_res : pc;
  assign wdata    = b_q;
  assign we       = (state == MEM) && is_store;
  assign mem_size = (state == MEM) ? size : SZ_WORD;
  assign mem_sign = (state == MEM) && sign_ext;
  assign done     = req && ack; // transfer finished this cycle

  assign rd_we  = (state == WB) && writes_rd;
  assign rd_idx = rd;
  assign rd_val = res_q;

  always_ff @(posedge clk_in or negedge rst_n) begin
    if (!rst_n) begin
      state  <= FETCH;
      pc     <= RESET_PC;
      npc    <= RESET_PC;
      req    <= 1'b0;
      halted <= 1'b0;
    end else if (rdy_in) begin
      case (state)
        FETCH, MEM: begin
          if (done) begin
            req   <= 1'b0;
            state <= (state == FETCH) ? DECODE : WB;
            if (state == MEM && is_store && addr == IO_HALT)
              halted <= 1'b1;
          end else if (!req && !ack) begin
            req <= 1'b1; // previous ack has dropped
          end
        end
        DECODE: state <= EXEC;
        EXEC: begin
          case (opcode)
            OPC_JAL:    npc <= alu_res;
            OPC_JALR:   npc <= alu_res & ~32'd1;
            OPC_BRANCH: npc <= taken ? br_target : pc_plus4;
            default:    npc <= pc_plus4;
          endcase
          state <= (is_load || is_store) ? MEM : WB;
        end
        default: begin // WB
          pc <= npc;
          if (!halted)
            state <= FETCH; // halted core parks here
        end
      endcase
    end
  end

  // instruction, operands and result
  always_ff @(posedge clk_in) begin
    if (rdy_in) begin
      if (state == FETCH && done)
        ir <= rdata;
      if (state == DECODE) begin
        a_q <= rs1_val;
        b_q <= rs2_val;
      end
      if (state == EXEC)
        res_q <= is_link ? pc_plus4 : alu_res; // link address for jumps
      if (state == MEM && done && is_load)
        res_q <= rdata;
    end
  end

endmodule

`default_nettype wire

// File: verilog/mem_unit.sv
// byte bus access unit
`default_nettype none
`timescale 1ns/1ns

module mem_unit import cpu_pkg::*; (
  input  wire            clk_in,
  input  wire            rst_n,
  input  wire            rdy_in,
  input  wire            io_buffer_full,
  input  wire            req,
  input  wire word_t     addr,
  input  wire word_t     wdata,
  input  wire            we,
  input  wire mem_size_e size,
  input  wire            sign_ext,
  input  wire byte_t     mem_din,
  output logic           ack,
  output word_t          rdata,
  output byte_t          mem_dout,
  output word_t          mem_a,
  output logic           mem_wr
);

  logic ack_q;
  logic [1:0] lane, last_lane; // byte lane, low byte first
  logic phase;                 // 0 issue, 1 sample
  logic active, io_stall;
  word_t buf_q;                // assembled read word

  assign ack       = ack_q;
  assign active    = req && !ack_q;
  assign last_lane = (size == SZ_BYTE) ? 2'd0 : (size == SZ_HALF) ? 2'd1 : 2'd3;
  assign io_stall  = we && (addr[17:16] == IO_BASE[17:16]) && io_buffer_full;

  assign mem_a    = addr + {30'd0, lane};
  assign mem_dout = wdata[{lane, 3'b000} +: 8];
  assign mem_wr   = active && we && !phase && rdy_in && !io_stall;

  always_ff @(posedge clk_in or negedge rst_n) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
      lane  <= 2'd0;
      phase <= 1'b0;
    end else if (rdy_in) begin
      if (!req) begin
        ack_q <= 1'b0; // req gone, finish the handshake
        lane  <= 2'd0;
        phase <= 1'b0;
      end else if (!ack_q) begin
        if (!phase) begin
          if (!io_stall)
            phase <= 1'b1; // hold the write while uart is full
        end else begin
          phase <= 1'b0;
          if (lane == last_lane) begin
            ack_q <= 1'b1;
            lane  <= 2'd0;
          end else begin
            lane <= lane + 2'd1;
          end
        end
      end
    end
  end

  // read byte arrives one cycle after issue
  always_ff @(posedge clk_in) begin
    if (rdy_in && active && phase && !we)
      buf_q[{lane, 3'b000} +: 8] <= mem_din;
  end

  always_comb begin
    case (size)
      SZ_BYTE: rdata = sign_ext ? {{24{buf_q[7]}}, buf_q[7:0]} : {24'd0, buf_q[7:0]};
      SZ_HALF: rdata = sign_ext ? {{16{buf_q[15]}}, buf_q[15:0]} : {16'd0, buf_q[15:0]};
      default: rdata = buf_q;
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/reg_file.sv
// integer register file
`default_nettype none
`timescale 1ns/1ns

module reg_file import cpu_pkg::*; (
  input  wire           clk_in,
  input  wire           rst_n,
  input  wire           rdy_in,
  input  wire reg_idx_t rs1,
  input  wire reg_idx_t rs2,
  input  wire           we,
  input  wire reg_idx_t rd,
  input  wire word_t    wdata,
  output word_t         rs1_val,
  output word_t         rs2_val,
  output word_t         dbg_a0 // x10 for debug
);

  word_t regs [32];

  assign rs1_val = regs[rs1];
  assign rs2_val = regs[rs2];
  assign dbg_a0  = regs[10];

  always_ff @(posedge clk_in or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++)
        regs[i] <= '0;
    end else if (rdy_in && we && rd != 5'd0) begin
      regs[rd] <= wdata; // x0 stays zero
    end
  end

endmodule

`default_nettype wire

// File: verilog/decoder.sv
// instruction decoder
`default_nettype none
`timescale 1ns/1ns

module decoder import cpu_pkg::*; (
  input  wire word_t instr,
  output opcode_e    opcode,
  output alu_op_e    alu_op,
  output word_t      imm,
  output reg_idx_t   rs1,
  output reg_idx_t   rs2,
  output reg_idx_t   rd,
  output mem_size_e  size,
  output logic       sign_ext
);

  // funct3 to alu operation, alt picks sub or sra
  function automatic alu_op_e f3_op(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  assign opcode   = opcode_e'(instr[6:0]);
  assign rs1      = instr[19:15];
  assign rs2      = instr[24:20];
  assign rd       = instr[11:7];
  assign sign_ext = !instr[14]; // lbu/lhu have funct3[2] set
  assign size     = (instr[13:12] == 2'b00) ? SZ_BYTE :
                    (instr[13:12] == 2'b01) ? SZ_HALF : SZ_WORD;

  always_comb begin
    case (opcode)
      OPC_LUI, OPC_AUIPC: imm = {instr[31:12], 12'd0};
      OPC_JAL:    imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      OPC_BRANCH: imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      OPC_STORE:  imm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
      default:    imm = {{21{instr[31]}}, instr[30:20]}; // i-type
    endcase
  end

  always_comb begin
    case (opcode)
      OPC_LUI: alu_op = ALU_PASS_B;
      OPC_OP:  alu_op = f3_op(instr[14:12], instr[30]);
      OPC_IMM: alu_op = f3_op(instr[14:12], instr[30] && (instr[14:12] == 3'b101)); // no subi
      OPC_BRANCH: begin
        case (instr[14:13])
          2'b00:   alu_op = ALU_EQ;   // beq bne
          2'b10:   alu_op = ALU_SLT;  // blt bge
          2'b11:   alu_op = ALU_SLTU; // bltu bgeu
          default: alu_op = ALU_ADD;  // reserved
        endcase
      end
      default: alu_op = ALU_ADD; // address and pc arithmetic
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/alu.sv
// integer alu
`default_nettype none
`timescale 1ns/1ns

module alu import cpu_pkg::*; (
  input  wire word_t   a,
  input  wire word_t   b,
  input  wire alu_op_e op,
  output word_t        res,
  output logic         cmp_true // branch decision before inversion
);

  always_comb begin
    cmp_true = 1'b0;
    res      = b;
    case (op)
      ALU_ADD:  res = a + b;
      ALU_SUB:  res = a - b;
      ALU_AND:  res = a & b;
      ALU_OR:   res = a | b;
      ALU_XOR:  res = a ^ b;
      ALU_SLL:  res = a << b[4:0];
      ALU_SRL:  res = a >> b[4:0];
      ALU_SRA:  res = word_t'($signed(a) >>> b[4:0]);
      ALU_SLT: begin
        cmp_true = $signed(a) < $signed(b);
        res      = {31'd0, cmp_true};
      end
      ALU_SLTU: begin
        cmp_true = a < b;
        res      = {31'd0, cmp_true};
      end
      ALU_EQ: begin
        cmp_true = a == b;
        res      = {31'd0, cmp_true};
      end
      default: res = b; // pass b
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/cpu_pkg.sv
// rv32i core shared types
`default_nettype none

package cpu_pkg;

  typedef logic [31:0] word_t;    // data or address word
  typedef logic [7:0]  byte_t;    // external bus byte
  typedef logic [4:0]  reg_idx_t; // register index

  // major opcodes handled by the core
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_IMM    = 7'b0010011,
    OPC_OP     = 7'b0110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
    ALU_EQ,     // branch equality
    ALU_PASS_B  // lui
  } alu_op_e;

  typedef enum logic [1:0] {SZ_BYTE, SZ_HALF, SZ_WORD} mem_size_e;

  typedef enum logic [2:0] {FETCH, DECODE, EXEC, MEM, WB} ctrl_state_e;

  // memory map
  localparam word_t IO_BASE  = 32'h0003_0000; // uart tx byte
  localparam word_t IO_HALT  = 32'h0003_0004; // write stops the program
  localparam word_t RESET_PC = 32'h0000_0000;

endpackage

`default_nettype wire
